//--- logic/num_text_pkg.sv
// ---------------------------------------------------------
// num_text package
// register map, state encodings and character constants
// shared by the number-to-text peripheral
// ---------------------------------------------------------
`default_nettype none

package num_text_pkg;

    // binary input width and decimal digit count
    localparam int VALUE_W    = 14;
    localparam int NUM_DIGITS = 5;

    // APB word addresses
    typedef enum logic [3:0] {
        REG_VALUE  = 4'h0,
        REG_CTRL   = 4'h4,
        REG_STATUS = 4'h8
    } reg_addr_e;

    typedef logic [7:0] char_t;

    // digit character is {3, bcd}
    localparam logic [3:0] ASCII_DIGIT_HI = 4'h3;
    localparam char_t      ASCII_LF       = 8'h0A;

    // character streamer FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SEND,
        ST_WAIT_TX
    } stream_state_e;

    // uart transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

//--- logic/bin_to_bcd.sv
// ---------------------------------------------------------
// bin_to_bcd
// combinational shift-and-add-3 converter, 14-bit binary
// to five packed BCD digits
// ---------------------------------------------------------
`default_nettype none

module bin_to_bcd (
    input  wire logic [num_text_pkg::VALUE_W-1:0]      value,
    output wire logic [4*num_text_pkg::NUM_DIGITS-1:0] bcd
);
    import num_text_pkg::*;

    localparam int BCD_W = 4 * NUM_DIGITS;

    // add 3 to any nibble above 4
    function automatic logic [3:0] add3(input logic [3:0] x);
        case (x)
            4'd0:    add3 = 4'd0;
            4'd1:    add3 = 4'd1;
            4'd2:    add3 = 4'd2;
            4'd3:    add3 = 4'd3;
            4'd4:    add3 = 4'd4;
            4'd5:    add3 = 4'd8;
            4'd6:    add3 = 4'd9;
            4'd7:    add3 = 4'd10;
            4'd8:    add3 = 4'd11;
            4'd9:    add3 = 4'd12;
            default: add3 = 4'd0;
        endcase
    endfunction

    // stage s holds the top s bits of value in BCD
    wire logic [BCD_W-1:0] shreg [0:VALUE_W];

    assign shreg[0] = '0;

    for (genvar s = 0; s < VALUE_W; s++) begin : g_stage
        wire logic [BCD_W-1:0] adj;

        for (genvar d = 0; d < NUM_DIGITS; d++) begin : g_digit
            // a digit can reach 5 only once the partial value can reach 5*10^d
            if ((1 << s) > 5 * (10 ** d)) begin : g_cell
                assign adj[4*d +: 4] = add3(shreg[s][4*d +: 4]);
            end else begin : g_pass
                assign adj[4*d +: 4] = shreg[s][4*d +: 4];
            end
        end

        // shift left and bring in the next bit MSB first
        assign shreg[s+1] = {adj[BCD_W-2:0], value[VALUE_W-1-s]};
    end

    assign bcd = shreg[VALUE_W];

    // value is unknown until the register block leaves reset
    for (genvar d = 0; d < NUM_DIGITS; d++) begin : g_check
        always_comb begin
            a_digit_range: assert final ($isunknown(value) || bcd[4*d +: 4] <= 4'd9)
                else $error("bcd digit %0d above 9 for value %0d", d, value);
        end
    end

endmodule

`default_nettype wire

//--- logic/num_text_regs.sv
// ---------------------------------------------------------
// num_text_regs
// APB slave with VALUE, CTRL and STATUS registers, raises
// a one-cycle start on an accepted VALUE write
// ---------------------------------------------------------
`default_nettype none

module num_text_regs (
    input  wire logic                              clk,
    input  wire logic                              reset,

    // APB
    input  wire logic                              psel,
    input  wire logic                              penable,
    input  wire logic                              pwrite,
    input  wire logic [3:0]                        paddr,
    input  wire logic [31:0]                       pwdata,
    output      logic [31:0]                       prdata,
    output wire logic                              pready,
    output      logic                              pslverr,

    input  wire logic                              busy,
    output      logic [num_text_pkg::VALUE_W-1:0]  value,
    output      logic                              blank_zeros,
    output      logic                              add_newline,
    output      logic                              start
);
    import num_text_pkg::*;

    logic access;
    logic wr_access;
    logic addr_ok;
    logic busy_any;
    logic value_refused;

    // no wait states
    assign pready = 1'b1;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // a start still in flight counts as busy
    assign busy_any = busy || start;

    always_comb begin
        case (paddr)
            REG_VALUE, REG_CTRL, REG_STATUS: addr_ok = 1'b1;
            default:                         addr_ok = 1'b0;
        endcase
    end

    assign value_refused = pwrite && (paddr == REG_VALUE) && busy_any;

    // error only during the access phase
    assign pslverr = access && (!addr_ok || value_refused);

    // read mux, zero outside a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_VALUE:  prdata = {{(32-VALUE_W){1'b0}}, value};
                REG_CTRL:   prdata = {30'd0, add_newline, blank_zeros};
                REG_STATUS: prdata = {31'd0, busy_any};
                default:    prdata = '0;
            endcase
        end
    end

    // writes land at the edge ending the access phase
    always_ff @(posedge clk) begin
        if (reset) begin
            value       <= '0;
            blank_zeros <= 1'b0;
            add_newline <= 1'b0;
            start       <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_access) begin
                case (paddr)
                    REG_VALUE: begin
                        if (!busy_any) begin
                            value <= pwdata[VALUE_W-1:0];
                            start <= 1'b1;
                        end
                    end
                    REG_CTRL: begin
                        blank_zeros <= pwdata[0];
                        add_newline <= pwdata[1];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // start must never overlap a running string
    a_start_not_busy: assert property (
        @(posedge clk) disable iff (reset)
        start |-> !busy
    ) else $error("start raised while streamer busy");

    // APB protocol: access phase needs select
    a_penable_psel: assert property (
        @(posedge clk) disable iff (reset)
        penable |-> psel
    ) else $error("penable high without psel");

endmodule

`default_nettype wire

//--- logic/char_streamer.sv
// ---------------------------------------------------------
// char_streamer
// latches the BCD digits, applies zero blanking and the
// line feed, hands characters to the uart one by one
// ---------------------------------------------------------
`default_nettype none

module char_streamer (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  start,
    input  wire logic [4*num_text_pkg::NUM_DIGITS-1:0] bcd,
    input  wire logic                                  blank_zeros,
    input  wire logic                                  add_newline,
    output wire logic                                  busy,
    output      num_text_pkg::char_t                   tx_data,
    output wire logic                                  tx_valid,
    input  wire logic                                  tx_ready
);
    import num_text_pkg::*;

    // digit index 0 is the most significant, NUM_DIGITS is the LF slot
    localparam int IDX_W = $clog2(NUM_DIGITS + 1);
    localparam logic [IDX_W-1:0] LF_IDX   = IDX_W'(NUM_DIGITS);
    localparam logic [IDX_W-1:0] UNIT_IDX = IDX_W'(NUM_DIGITS - 1);

    stream_state_e              state;
    logic [IDX_W-1:0]           idx;
    logic [IDX_W-1:0]           first_idx;
    logic [4*NUM_DIGITS-1:0]    digits_q;
    logic                       blank_q;
    logic                       nl_q;
    logic [3:0]                 cur_digit;
    logic                       last_char;

    // snapshot of the number and options
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            digits_q <= bcd;
            blank_q  <= blank_zeros;
            nl_q     <= add_newline;
        end
    end

    // first nonzero digit, units digit is always kept
    always_comb begin
        first_idx = '0;
        if (blank_q) begin
            first_idx = UNIT_IDX;
            for (int i = NUM_DIGITS - 2; i >= 0; i--) begin
                if (digits_q[4*(NUM_DIGITS-1-i) +: 4] != 4'd0)
                    first_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        cur_digit = 4'd0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (idx == IDX_W'(i))
                cur_digit = digits_q[4*(NUM_DIGITS-1-i) +: 4];
        end
    end

    assign tx_data   = (idx == LF_IDX) ? ASCII_LF : {ASCII_DIGIT_HI, cur_digit};
    assign tx_valid  = (state == ST_SEND);
    assign busy      = (state != ST_IDLE);
    assign last_char = (idx == LF_IDX) || (idx == UNIT_IDX && !nl_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start)
                        state <= ST_LOAD;
                end
                ST_LOAD: begin
                    idx   <= first_idx;
                    state <= ST_SEND;
                end
                ST_SEND: begin
                    if (tx_valid && tx_ready) begin
                        if (last_char)
                            state <= ST_WAIT_TX;
                        else
                            idx <= idx + 1'b1;
                    end
                end
                // uart returns to idle once the stop bit is out
                ST_WAIT_TX: begin
                    if (tx_ready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_tx_hold: assert property (
        @(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
    ) else $error("tx_data changed before handshake");

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
// ---------------------------------------------------------
// uart_tx
// 8N1 serial transmitter, LSB first, bit period set by
// CLKS_PER_BIT
// ---------------------------------------------------------
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire num_text_pkg::char_t  tx_data,
    input  wire logic                 tx_valid,
    output wire logic                 tx_ready,
    output      logic                 txd
);
    import num_text_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

    tx_state_e          state;
    logic [CNT_W-1:0]   clk_cnt;
    logic [2:0]         bit_idx;
    char_t              shift_q;
    logic               bit_end;

    assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign tx_ready = (state == TX_IDLE);

    // shift register holds payload only
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_valid)
            shift_q <= tx_data;
        else if (bit_end && (state == TX_START || state == TX_DATA))
            shift_q <= {1'b0, shift_q[7:1]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    txd     <= 1'b1;
                    if (tx_valid) begin
                        state <= TX_START;
                        txd   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state <= TX_DATA;
                        txd   <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_idle_high: assert property (
        @(posedge clk) disable iff (reset)
        state == TX_IDLE |-> txd
    ) else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

//--- logic/num_text_top.sv
// ---------------------------------------------------------
// num_text_top
// APB peripheral that prints a binary value as decimal
// text on a serial line
// ---------------------------------------------------------
`default_nettype none

module num_text_top #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [3:0]  paddr,
    input  wire logic [31:0] pwdata,
    output wire logic [31:0] prdata,
    output wire logic        pready,
    output wire logic        pslverr,
    output wire logic        txd
);
    import num_text_pkg::*;

    wire logic [VALUE_W-1:0]      value;
    wire logic                    blank_zeros;
    wire logic                    add_newline;
    wire logic                    start;
    wire logic                    busy;
    wire logic [4*NUM_DIGITS-1:0] bcd;
    char_t                        tx_data;
    wire logic                    tx_valid;
    wire logic                    tx_ready;

    num_text_regs regs0 (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .busy        (busy),
        .value       (value),
        .blank_zeros (blank_zeros),
        .add_newline (add_newline),
        .start       (start)
    );

    bin_to_bcd conv0 (
        .value (value),
        .bcd   (bcd)
    );

    char_streamer stream0 (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .bcd         (bcd),
        .blank_zeros (blank_zeros),
        .add_newline (add_newline),
        .busy        (busy),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) tx0 (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

endmodule

`default_nettype wire

//--- dv/num_text_tb.sv
// ---------------------------------------------------------
// num_text_tb
// APB stimulus table, serial line decoder and checks for
// the number-to-text peripheral
// ---------------------------------------------------------
`default_nettype none

module num_text_tb;
    import num_text_pkg::*;

    localparam int CLKS_PER_BIT  = 8;
    localparam int N_FIXED       = 13;
    localparam int N_ENTRIES     = 17;
    localparam int WATCHDOG_TIME = N_ENTRIES * 7 * 10 * CLKS_PER_BIT * 4 * 2;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        txd;

    int     errors = 0;
    integer seed   = 32'h7d22_6994;
    char_t  rx_q[$];
    char_t  exp_q[$];

    // stimulus table of value, blank_zeros and add_newline
    // entries from N_FIXED on are filled at random
    int unsigned tbl_value [0:N_ENTRIES-1] =
        '{0, 9, 10, 4999, 9999, 10000, 16383, 0, 42, 305, 7, 0, 12345, 0, 0, 0, 0};
    bit tbl_blank [0:N_ENTRIES-1] = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1, 1, 0, 0, 0, 0};
    bit tbl_nl    [0:N_ENTRIES-1] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 0, 0, 0, 0};

    num_text_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .txd     (txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // setup and access phase with the response sampled mid access phase
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        err = pslverr;
        check_ready(pready, 1'b1, "write");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        check_ready(pready, 1'b1, "read");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_char(input char_t got, input char_t exp, input int pos);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: character %0d is 8'h%02h, expected 8'h%02h",
                     $time, pos, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s read 32'h%08h, expected 32'h%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: pslverr %b on %s, expected %b", $time, got, what, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: pready %b in %s access phase, expected %b",
                     $time, got, what, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: txd is %b %s, expected %b", $time, got, what, exp);
        end
    endtask

    // five decimal digits MSB first with optional blanking and LF
    function automatic void build_expected(input int unsigned v, input bit blank,
                                           input bit nl);
        int unsigned d;
        bit          started;
        exp_q.delete();
        started = !blank;
        for (int k = 4; k >= 0; k--) begin
            d = (v / (10 ** k)) % 10;
            if (d != 0 || k == 0)
                started = 1'b1;
            if (started)
                exp_q.push_back(8'h30 + d[7:0]);
        end
        if (nl)
            exp_q.push_back(8'h0A);
    endfunction

    // samples every cycle of a frame at the falling clock edge
    initial begin : uart_decoder
        char_t rx;
        logic  level;
        forever begin
            @(negedge clk);
            if (!reset && txd === 1'b0) begin
                for (int b = 0; b < 10; b++) begin
                    if (b > 0)
                        @(negedge clk);
                    level = txd;
                    for (int c = 1; c < CLKS_PER_BIT; c++) begin
                        @(negedge clk);
                        if (txd !== level) begin
                            errors++;
                            $display("Error at %0t: txd changed inside bit %0d", $time, b);
                        end
                    end
                    if (b >= 1 && b <= 8)
                        rx[b-1] = level;
                    if (b == 9 && level !== 1'b1) begin
                        errors++;
                        $display("Error at %0t: stop bit is low", $time);
                    end
                end
                rx_q.push_back(rx);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Checks stopped, %0d errors", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] rdata;
        logic        err;
        int          r;
        int unsigned v;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = 32'h0;
        reset   = 1'b1;
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            r = $random(seed);
            tbl_value[i] = $unsigned(r) % 16384;
            tbl_blank[i] = r[20];
            tbl_nl[i]    = r[25];
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_level(txd, 1'b1, "after reset");

        apb_read(REG_VALUE, rdata, err);
        check_word(rdata, 32'd0, "VALUE after reset");
        apb_read(REG_CTRL, rdata, err);
        check_word(rdata, 32'd0, "CTRL after reset");
        apb_read(REG_STATUS, rdata, err);
        check_word(rdata, 32'd0, "STATUS after reset");

        // unmapped address
        apb_read(4'hC, rdata, err);
        check_err(err, 1'b1, "read of 0xC");
        apb_write(4'hC, 32'h1234, err);
        check_err(err, 1'b1, "write of 0xC");

        for (int i = 0; i < N_ENTRIES; i++) begin
            v = tbl_value[i];
            build_expected(v, tbl_blank[i], tbl_nl[i]);
            apb_write(REG_CTRL, {30'd0, tbl_nl[i], tbl_blank[i]}, err);
            check_err(err, 1'b0, "CTRL write");
            apb_read(REG_CTRL, rdata, err);
            check_word(rdata, {30'd0, tbl_nl[i], tbl_blank[i]}, "CTRL");
            rx_q.delete();
            apb_write(REG_VALUE, v, err);
            check_err(err, 1'b0, "VALUE write");
            apb_read(REG_STATUS, rdata, err);
            check_word(rdata, 32'd1, "STATUS after VALUE write");
            // second number while busy must be refused
            apb_write(REG_VALUE, (v + 1111) % 16384, err);
            check_err(err, 1'b1, "VALUE write while busy");
            rdata = 32'd1;
            while (rdata[0])
                apb_read(REG_STATUS, rdata, err);
            check_level(txd, 1'b1, "after a string");
            apb_read(REG_VALUE, rdata, err);
            check_word(rdata, v, "VALUE");
            if (rx_q.size() != exp_q.size()) begin
                errors++;
                $display("Error at %0t: value %0d gave %0d characters, expected %0d",
                         $time, v, rx_q.size(), exp_q.size());
            end
            for (int k = 0; k < exp_q.size() && k < rx_q.size(); k++)
                check_char(rx_q[k], exp_q[k], k);
        end

        $display("Checks done, %0d errors", errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- num_text_top.f
logic/num_text_pkg.sv
logic/bin_to_bcd.sv
logic/num_text_regs.sv
logic/char_streamer.sv
logic/uart_tx.sv
logic/num_text_top.sv
dv/num_text_tb.sv
